// File: Makefile
# Verilator build of the ALU testbench

TB_TOP  = alu_tb
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TB_TOP) -f alu.f \
		-Mdir $(OBJ_DIR) -o V$(TB_TOP)

# A $fatal in the testbench gives a non-zero exit status
run: compile
	./$(OBJ_DIR)/V$(TB_TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: alu.f
verilog/alu_pkg.sv
verilog/alu_req_if.sv
verilog/alu_ctrl.sv
verilog/alu_arith.sv
verilog/alu_bitops.sv
verilog/alu_transpose.sv
verilog/alu.sv
test/alu_assertions.sv
test/alu_tb.sv

// File: test/alu_assertions.sv
`timescale 1ns/1ns

module alu_assertions import alu_pkg::*; (
    input logic              i_clk,
    input logic              i_rst_n,
    input logic              i_in_valid,
    input logic [INST_W-1:0] i_inst,
    input logic              i_out_valid,
    input logic              i_busy,
    input logic              i_read_row,
    input logic              i_load_done
);

    // Back-to-back valid cycles only come from the matrix read-out
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_out_valid && $past(i_out_valid)) |-> $past(i_read_row))
    else $error("o_out_valid high twice outside the matrix output");

    // A single request taken at the ports holds busy during its result cycle
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_in_valid && !i_busy && i_inst != OP_TRANSPOSE) |=> (i_busy && i_out_valid))
    else $error("o_busy or o_out_valid missing after a single accept");

    // Eight rows, then a gap
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_load_done |=> i_out_valid ##1 i_out_valid ##1 i_out_valid ##1 i_out_valid
            ##1 i_out_valid ##1 i_out_valid ##1 i_out_valid ##1 i_out_valid
            ##1 !i_out_valid)
    else $error("transpose output is not eight consecutive rows");

endmodule

bind alu_ctrl alu_assertions u_assertions (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_in_valid  (i_in_valid),
    .i_inst      (i_inst),
    .i_out_valid (o_out_valid),
    .i_busy      (o_busy),
    .i_read_row  (o_read_row),
    .i_load_done (load_done)
);

// File: test/alu_tb.sv
`timescale 1ns/1ns

module alu_tb import alu_pkg::*; ();

    localparam int MAX_CYCLES = 4000;   // Over five times the test length

    logic              i_clk;
    logic              i_rst_n;
    logic              i_in_valid;
    logic [INST_W-1:0] i_inst;
    data_t             i_data_a;
    data_t             i_data_b;
    logic              o_busy;
    logic              o_out_valid;
    data_t             o_data;

    integer seed;
    longint ref_acc;             // Model accumulator, 36-bit range
    data_t  exp_q[$];
    data_t  load_cols[MAT_N];    // Columns of the matrix being loaded
    int     load_cnt;
    int     valid_due;           // Valid cycles owed by the DUT
    int     cycles;

    alu i_dut (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_in_valid  (i_in_valid),
        .i_inst      (i_inst),
        .i_data_a    (i_data_a),
        .i_data_b    (i_data_b),
        .o_busy      (o_busy),
        .o_out_valid (o_out_valid),
        .o_data      (o_data)
    );

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    function automatic data_t sat16(input longint v);
        if (v > 32767) return DATA_MAX;
        if (v < -32768) return DATA_MIN;
        return data_t'(v);
    endfunction

    function automatic longint clamp_acc(input longint v);
        if (v > (64'sd1 <<< 35) - 1) return (64'sd1 <<< 35) - 1;
        if (v < -(64'sd1 <<< 35)) return -(64'sd1 <<< 35);
        return v;
    endfunction

    // Expected result of one single operation, updates the model accumulator
    function data_t ref_alu(input logic [INST_W-1:0] op, input data_t a, input data_t b);
        longint      sum;
        longint      q;
        logic [15:0] ua;
        int          n;
        ua = a;
        case (op)
            OP_ADD: return sat16(longint'(a) + longint'(b));
            OP_SUB: return sat16(longint'(a) - longint'(b));
            OP_MAC: begin
                sum = ref_acc + longint'(a) * longint'(b);
                q   = sum >>> FRAC_W;   // Floor
                if ((sum & 1023) >= 512) q = q + 1;
                ref_acc = clamp_acc(sum);
                return sat16(q);
            end
            OP_GRAY: return data_t'(ua ^ (ua >> 1));
            OP_ROR: begin
                n = int'($unsigned(b));
                if (n == 0 || n == 16) return a;
                return data_t'((ua >> n) | (ua << (16 - n)));
            end
            OP_CLZ: begin
                n = 16;   // Zero word
                for (int i = 0; i < 16; i++) begin
                    if (ua[i]) n = 15 - i;
                end
                return data_t'(n);
            end
            default: return '0;
        endcase
    endfunction

    // Row r holds bit pair r of every column, column 0 on top
    function automatic data_t transpose_row(input int r);
        data_t row;
        for (int c = 0; c < MAT_N; c++) begin
            row[15-2*c -: 2] = load_cols[c][15-2*r -: 2];
        end
        return row;
    endfunction

    function automatic data_t rand_word();
        return data_t'($random(seed));
    endfunction

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            report_fail("Timeout: the run did not finish within the cycle limit");
        end
    end

    // Timing and data check, then record this edge's accept
    always @(posedge i_clk) begin
        if (i_rst_n) begin
            assert (o_busy === (valid_due > 0 || load_cnt > 0))
            else report_fail("o_busy does not match the pending requests");
            if (valid_due > 0) begin
                assert (o_out_valid) else report_fail("o_out_valid missing when a result was due");
                valid_due--;
            end else begin
                assert (!o_out_valid) else report_fail("o_out_valid high with no result due");
            end
            if (o_out_valid) begin
                assert (exp_q.size() > 0) else report_fail("Output word with nothing expected");
                assert (o_data === exp_q[0])
                else report_fail($sformatf("FAIL %0t ns: o_data %h, expected %h",
                                           $time, o_data, exp_q[0]));
                void'(exp_q.pop_front());
            end
            if (i_in_valid && (!o_busy || load_cnt > 0)) begin
                if (load_cnt > 0) begin
                    load_cols[load_cnt] = i_data_a;
                    load_cnt++;
                    if (load_cnt == MAT_N) begin
                        for (int r = 0; r < MAT_N; r++) exp_q.push_back(transpose_row(r));
                        valid_due = MAT_N;
                        load_cnt  = 0;
                    end
                end else if (i_inst == OP_TRANSPOSE) begin
                    load_cols[0] = i_data_a;
                    load_cnt     = 1;
                end else begin
                    exp_q.push_back(ref_alu(i_inst, i_data_a, i_data_b));
                    valid_due = 1;
                end
            end
        end
    end

    task automatic wait_idle();
        do begin
            @(posedge i_clk);
            #1;
        end while (o_busy);
    endtask

    // One request, optionally followed by a request offered while busy
    task automatic send(input logic [INST_W-1:0] op, input data_t a, input data_t b,
                        input bit poke);
        wait_idle();
        i_in_valid = 1'b1;
        i_inst     = op;
        i_data_a   = a;
        i_data_b   = b;
        @(posedge i_clk);
        #1;
        if (poke) begin
            i_inst   = INST_W'($random(seed));
            i_data_a = rand_word();
            @(posedge i_clk);
            #1;
        end
        i_in_valid = 1'b0;
    endtask

    task automatic send_transpose();
        int gap;
        send(OP_TRANSPOSE, rand_word(), '0, 0);
        for (int c = 1; c < MAT_N; c++) begin
            gap = int'($unsigned($random(seed)) % 3);
            repeat (gap) begin
                @(posedge i_clk);
                #1;
            end
            i_in_valid = 1'b1;
            i_inst     = INST_W'($random(seed));   // Ignored during the load
            i_data_a   = rand_word();
            @(posedge i_clk);
            #1;
            i_in_valid = 1'b0;
        end
    endtask

    initial begin
        seed       = 5;
        cycles     = 0;
        ref_acc    = 0;
        load_cnt   = 0;
        valid_due  = 0;
        i_rst_n    = 1'b0;
        i_in_valid = 1'b0;
        i_inst     = '0;
        i_data_a   = '0;
        i_data_b   = '0;
        repeat (16) @(posedge i_clk);
        #1 i_rst_n = 1'b1;

        repeat (20) begin
            send(OP_ADD, rand_word(), rand_word(), 0);
            send(OP_SUB, rand_word(), rand_word(), 1);
        end
        send(OP_ADD, DATA_MAX, DATA_MAX, 0);
        send(OP_ADD, DATA_MIN, DATA_MIN, 0);
        send(OP_ADD, DATA_MAX, 16'sd1, 0);
        send(OP_SUB, DATA_MIN, 16'sd1, 1);
        send(OP_SUB, DATA_MAX, DATA_MIN, 0);
        send(OP_SUB, DATA_MIN, DATA_MAX, 0);

        // MAC, ties first, then random, then growth into saturation
        send(OP_MAC, 16'sd1, 16'sd512, 0);
        send(OP_MAC, -16'sd1, 16'sd1024, 0);
        send(OP_MAC, 16'sd3, 16'sd512, 0);
        send(OP_MAC, -16'sd2, 16'sd512, 0);
        repeat (156) send(OP_MAC, rand_word(), rand_word(), 0);
        repeat (40) send(OP_MAC, DATA_MIN, DATA_MIN, 0);

        repeat (10) send(OP_GRAY, rand_word(), rand_word(), 0);
        for (int amt = 0; amt <= 16; amt++) send(OP_ROR, rand_word(), data_t'(amt), 0);
        send(OP_CLZ, '0, '0, 0);
        send(OP_CLZ, -16'sd1, '0, 0);
        for (int k = 0; k < 16; k++) send(OP_CLZ, data_t'($unsigned(rand_word()) >> k), '0, 1);

        for (int op = 3; op < 16; op++) begin
            if (op == 3 || op == 5 || op == 8 || op >= 10) begin
                send(INST_W'(op), rand_word(), rand_word(), 0);
            end
        end

        send_transpose();
        send_transpose();

        wait_idle();
        repeat (3) @(posedge i_clk);
        if (exp_q.size() == 0 && load_cnt == 0 && valid_due == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            report_fail("Run ended with expected outputs never produced");
        end
    end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ns

module alu import alu_pkg::*; (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_in_valid,
    input  logic [INST_W-1:0] i_inst,
    input  data_t             i_data_a,
    input  data_t             i_data_b,
    output logic              o_busy,
    output logic              o_out_valid,
    output data_t             o_data
);

    alu_req_if req ();

    data_t arith_res;
    data_t bit_res;
    data_t row;
    logic  load_last;
    logic  row_last;
    logic  read_row;

    alu_ctrl u_ctrl (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_in_valid  (i_in_valid),
        .i_inst      (i_inst),
        .i_data_a    (i_data_a),
        .i_data_b    (i_data_b),
        .o_busy      (o_busy),
        .o_out_valid (o_out_valid),
        .o_data      (o_data),
        .req         (req.ctrl),
        .i_arith_res (arith_res),
        .i_bit_res   (bit_res),
        .i_row       (row),
        .i_load_last (load_last),
        .i_row_last  (row_last),
        .o_read_row  (read_row)
    );

    alu_arith #(
        .ACC_W (ACC_W_DEF)
    ) u_arith (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .req         (req.unit),
        .o_arith_res (arith_res)
    );

    alu_bitops u_bitops (
        .req       (req.unit),
        .o_bit_res (bit_res)
    );

    alu_transpose u_transpose (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .req         (req.unit),
        .i_read_row  (read_row),
        .o_row       (row),
        .o_load_last (load_last),
        .o_row_last  (row_last)
    );

endmodule

// File: verilog/alu_arith.sv
`timescale 1ns/1ns

module alu_arith import alu_pkg::*; #(
    parameter int ACC_W = ACC_W_DEF
) (
    input  logic    i_clk,
    input  logic    i_rst_n,
    alu_req_if.unit req,
    output data_t   o_arith_res
);

    // Width of the rounded MAC result before output saturation
    localparam int WIDE_W = ACC_W - FRAC_W + 2;

    localparam logic signed [ACC_W-1:0] ACC_MAX = {1'b0, {(ACC_W-1){1'b1}}};
    localparam logic signed [ACC_W-1:0] ACC_MIN = {1'b1, {(ACC_W-1){1'b0}}};

    logic signed [ACC_W-1:0]    acc;
    logic signed [ACC_W-1:0]    acc_nxt;
    logic signed [DATA_W:0]     add_sum;    // One guard bit
    logic signed [DATA_W:0]     sub_diff;
    logic signed [2*DATA_W-1:0] prod;       // Q12.20
    logic signed [ACC_W:0]      acc_sum;
    logic signed [WIDE_W-2:0]   mac_trunc;
    logic                       round_up;
    logic signed [WIDE_W-1:0]   mac_rnd;

    // Clamp a wide signed value to one data word
    function automatic data_t sat_data(input logic signed [WIDE_W-1:0] v);
        if (v > DATA_MAX) begin
            return DATA_MAX;
        end
        if (v < DATA_MIN) begin
            return DATA_MIN;
        end
        return v[DATA_W-1:0];
    endfunction

    assign add_sum  = req.req_a + req.req_b;
    assign sub_diff = req.req_a - req.req_b;

    assign prod    = req.req_a * req.req_b;
    assign acc_sum = acc + prod;   // Product sign-extended to the accumulator

    // Drop the extra fraction bits, half rounds up
    assign mac_trunc = acc_sum[ACC_W:FRAC_W];
    assign round_up  = acc_sum[FRAC_W-1];   // Dropped bits >= 512
    assign mac_rnd   = mac_trunc + $signed({1'b0, round_up});

    always_comb begin
        if (acc_sum > ACC_MAX) begin
            acc_nxt = ACC_MAX;
        end else if (acc_sum < ACC_MIN) begin
            acc_nxt = ACC_MIN;
        end else begin
            acc_nxt = acc_sum[ACC_W-1:0];
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            acc <= '0;
        end else if (req.req_valid && req.req_op == OP_MAC) begin
            acc <= acc_nxt;
        end
    end

    always_comb begin
        case (req.req_op)
            OP_ADD:  o_arith_res = sat_data(add_sum);
            OP_SUB:  o_arith_res = sat_data(sub_diff);
            OP_MAC:  o_arith_res = sat_data(mac_rnd);   // From the unsaturated sum
            default: o_arith_res = '0;
        endcase
    end

endmodule

// File: verilog/alu_bitops.sv
`timescale 1ns/1ns

module alu_bitops import alu_pkg::*; (
    alu_req_if.unit req,
    output data_t   o_bit_res
);

    localparam int CNT_W = $clog2(DATA_W) + 1;   // Holds 0 to 16

    logic [DATA_W-1:0]   a_u;
    logic [DATA_W-1:0]   gray;
    logic [2*DATA_W-1:0] rot_wide;
    logic [CNT_W-1:0]    lz_cnt;
    logic                lz_found;

    assign a_u  = req.req_a;
    assign gray = (a_u >> 1) ^ a_u;

    // Doubled word, so an amount of 16 brings a back unchanged
    assign rot_wide = {a_u, a_u} >> $unsigned(req.req_b);

    // Leading zeros from the MSB, 16 for a zero word
    always_comb begin
        lz_cnt   = '0;
        lz_found = 1'b0;
        for (int i = DATA_W - 1; i >= 0; i--) begin
            if (a_u[i]) begin
                lz_found = 1'b1;
            end else if (!lz_found) begin
                lz_cnt = lz_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        case (req.req_op)
            OP_GRAY: o_bit_res = gray;
            OP_ROR:  o_bit_res = rot_wide[DATA_W-1:0];
            OP_CLZ:  o_bit_res = DATA_W'(lz_cnt);
            default: o_bit_res = '0;
        endcase
    end

endmodule

// File: verilog/alu_ctrl.sv
`timescale 1ns/1ns

module alu_ctrl import alu_pkg::*; (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_in_valid,
    input  logic [INST_W-1:0] i_inst,
    input  data_t             i_data_a,
    input  data_t             i_data_b,
    output logic              o_busy,
    output logic              o_out_valid,
    output data_t             o_data,
    alu_req_if.ctrl           req,
    input  data_t             i_arith_res,
    input  data_t             i_bit_res,
    input  data_t             i_row,
    input  logic              i_load_last,
    input  logic              i_row_last,
    output logic              o_read_row
);

    typedef enum logic [1:0] {S_IDLE, S_BUSY, S_LOAD, S_OUT} state_e;

    state_e state;
    state_e state_nxt;
    op_e    op_in;
    logic   accept;
    logic   single_acc;   // Non-transpose accept, answered next cycle
    logic   load_done;    // Column 7 accepted
    data_t  res_sel;

    assign op_in      = op_e'(i_inst);
    assign accept     = i_in_valid && (state == S_IDLE || state == S_LOAD);
    assign single_acc = accept && (state == S_IDLE) && (op_in != OP_TRANSPOSE);
    assign load_done  = accept && (state == S_LOAD) && i_load_last;

    assign o_busy     = (state != S_IDLE);
    assign o_read_row = (state == S_OUT);   // Advance one row per cycle

    // Column writes during the load always go to the transpose unit
    assign req.req_valid = accept;
    assign req.req_op    = (state == S_LOAD) ? OP_TRANSPOSE : op_in;
    assign req.req_a     = i_data_a;
    assign req.req_b     = i_data_b;

    always_comb begin
        case (op_in)
            OP_ADD, OP_SUB, OP_MAC:  res_sel = i_arith_res;
            OP_GRAY, OP_ROR, OP_CLZ: res_sel = i_bit_res;
            default:                 res_sel = '0;   // Unimplemented opcode
        endcase
    end

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (accept) begin
                    state_nxt = (op_in == OP_TRANSPOSE) ? S_LOAD : S_BUSY;
                end
            end
            S_BUSY: state_nxt = S_IDLE;
            S_LOAD: begin
                if (load_done) begin
                    state_nxt = S_OUT;
                end
            end
            S_OUT: begin
                // Last row is shown while in S_BUSY
                if (i_row_last) begin
                    state_nxt = S_BUSY;
                end
            end
            default: state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state       <= S_IDLE;
            o_out_valid <= 1'b0;
        end else begin
            state       <= state_nxt;
            o_out_valid <= single_acc || load_done || (state == S_OUT);
        end
    end

    always_ff @(posedge i_clk) begin
        if (single_acc) begin
            o_data <= res_sel;
        end else if (load_done || state == S_OUT) begin
            o_data <= i_row;   // Row 0 arrives with the column 7 bypass
        end
    end

endmodule

// File: verilog/alu_pkg.sv
package alu_pkg;

    // Data word, signed Q6.10
    localparam int DATA_W    = 16;
    localparam int FRAC_W    = 10;
    localparam int INST_W    = 4;
    localparam int ACC_W_DEF = 36;   // Default MAC accumulator width

    typedef logic signed [DATA_W-1:0] data_t;

    // Saturation limits of one data word
    localparam data_t DATA_MAX = {1'b0, {(DATA_W-1){1'b1}}};   // +32767
    localparam data_t DATA_MIN = {1'b1, {(DATA_W-1){1'b0}}};   // -32768

    // Implemented opcodes, every other code returns zero
    typedef enum logic [INST_W-1:0] {
        OP_ADD       = 0,
        OP_SUB       = 1,
        OP_MAC       = 2,
        OP_GRAY      = 4,
        OP_ROR       = 6,
        OP_CLZ       = 7,
        OP_TRANSPOSE = 9
    } op_e;

    // Transpose matrix, one column per data word
    localparam int MAT_N  = 8;
    localparam int ELEM_W = 2;

    typedef logic [$clog2(MAT_N)-1:0] idx_t;   // Row and column index

endpackage

// File: verilog/alu_req_if.sv
`timescale 1ns/1ns

// One accepted operation, forwarded from the controller to the units
interface alu_req_if import alu_pkg::*; ();

    logic  req_valid;   // One cycle per accept
    op_e   req_op;
    data_t req_a;
    data_t req_b;

    modport ctrl (
        output req_valid,
        output req_op,
        output req_a,
        output req_b
    );

    modport unit (
        input req_valid,
        input req_op,
        input req_a,
        input req_b
    );

endinterface

// File: verilog/alu_transpose.sv
`timescale 1ns/1ns

module alu_transpose import alu_pkg::*; (
    input  logic    i_clk,
    input  logic    i_rst_n,
    alu_req_if.unit req,
    input  logic    i_read_row,
    output data_t   o_row,
    output logic    o_load_last,
    output logic    o_row_last
);

    logic [ELEM_W-1:0] mat     [MAT_N][MAT_N];   // [row][col]
    logic [ELEM_W-1:0] new_col [MAT_N];          // Incoming column by row
    idx_t              col_cnt;
    idx_t              row_cnt;
    logic              col_wr;

    assign col_wr      = req.req_valid && (req.req_op == OP_TRANSPOSE);
    assign o_load_last = col_wr && (col_cnt == idx_t'(MAT_N - 1));
    assign o_row_last  = (row_cnt == idx_t'(MAT_N - 1));

    // Top bit pair of a is row 0
    always_comb begin
        for (int r = 0; r < MAT_N; r++) begin
            new_col[r] = req.req_a[DATA_W-1-ELEM_W*r -: ELEM_W];
        end
    end

    // Column counter wraps after column 7, so each load starts at column 0
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int r = 0; r < MAT_N; r++) begin
                for (int c = 0; c < MAT_N; c++) begin
                    mat[r][c] <= '0;
                end
            end
            col_cnt <= '0;
        end else if (col_wr) begin
            for (int r = 0; r < MAT_N; r++) begin
                mat[r][col_cnt] <= new_col[r];
            end
            col_cnt <= col_cnt + 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            row_cnt <= '0;
        end else if (col_wr && col_cnt == '0) begin
            row_cnt <= '0;   // New transpose
        end else if (i_read_row || o_load_last) begin
            row_cnt <= row_cnt + 1'b1;   // Row 0 leaves with column 7
        end
    end

    // Column 0 in the top bits; the column being written is bypassed
    always_comb begin
        for (int c = 0; c < MAT_N; c++) begin
            if (col_wr && col_cnt == idx_t'(c)) begin
                o_row[DATA_W-1-ELEM_W*c -: ELEM_W] = new_col[row_cnt];
            end else begin
                o_row[DATA_W-1-ELEM_W*c -: ELEM_W] = mat[row_cnt][c];
            end
        end
    end

endmodule
